// ==== cam_consts.svh ====
/* Image size and raster timing for the camera to VGA path.
   Included by the video package and by every block that sizes a counter. */
`ifndef CAM_CONSTS_SVH
`define CAM_CONSTS_SVH

// Captured image, stored row by row from address 0
`define IMG_W 32
`define IMG_H 24
`define IMG_PIXELS (`IMG_W * `IMG_H)

// Frame buffer address width, must cover IMG_PIXELS
`define ADDR_W 10

// Raster totals, active area sits top left
`define H_TOTAL 40
`define V_TOTAL 30

// Sync pulses are active low
`define H_SYNC_START 34
`define H_SYNC_LEN 4
`define V_SYNC_START 25
`define V_SYNC_LEN 2

`endif

// ==== video_pkg.sv ====
/* Pixel and address types shared by capture, frame buffers, filter passes
   and the VGA scanner. */
`include "cam_consts.svh"

package video_pkg;

    // Red in [11:8], green in [7:4], blue in [3:0]
    typedef logic [11:0] rgb444_t;

    // One colour channel or gray level
    typedef logic [3:0] nibble_t;

    // Word address into a frame buffer
    typedef logic [`ADDR_W-1:0] pix_addr_t;

endpackage

// ==== ctrl_pkg.sv ====
/* State encoding of the mode sequencer. */
package ctrl_pkg;

    // Each pass is followed by a one-cycle state that clears it
    typedef enum logic [2:0] {
        seq_idle,
        seq_gray,
        seq_gray_done,
        seq_edge,
        seq_edge_done
    } seq_state_t;

endpackage

// ==== pixel_capture.sv ====
/* Camera input side. Packs byte pairs from the camera bus into RGB444 words,
   writes them in raster order to frame buffer 1 and flags each frame end. */
`timescale 1ns/1ps
`include "cam_consts.svh"

module pixel_capture
    import video_pkg::*;
(
    input  logic       clk_25_vga,
    input  logic       reset_global,
    input  logic       cam_vsync,
    input  logic       cam_href,
    input  logic [7:0] cam_data,
    output logic       cap_we,
    output pix_addr_t  cap_addr,
    output rgb444_t    cap_data,
    output logic       frame_done
);

    localparam pix_addr_t LAST_ADDR = pix_addr_t'(`IMG_PIXELS - 1);

    logic      byte_phase;
    logic      frame_full;
    logic      vsync_q;
    pix_addr_t pix_cnt;
    nibble_t   red_q;

    always_ff @(posedge clk_25_vga or posedge reset_global) begin
        if (reset_global) begin
            byte_phase <= 1'b0;
            frame_full <= 1'b0;
            vsync_q    <= 1'b0;
            pix_cnt    <= '0;
            cap_we     <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            vsync_q    <= cam_vsync;
            frame_done <= cam_vsync & ~vsync_q;
            cap_we     <= 1'b0;
            if (cam_vsync) begin
                // Between frames, restart at address 0
                byte_phase <= 1'b0;
                frame_full <= 1'b0;
                pix_cnt    <= '0;
            end else if (cam_href) begin
                byte_phase <= ~byte_phase;
                if (byte_phase) begin
                    cap_we <= ~frame_full;
                    if (pix_cnt == LAST_ADDR) begin
                        frame_full <= 1'b1;
                    end else begin
                        pix_cnt <= pix_cnt + 1'b1;
                    end
                end
            end else begin
                byte_phase <= 1'b0;
            end
        end
    end

    // Pixel assembly, first byte holds red in its low nibble
    always_ff @(posedge clk_25_vga) begin
        if (cam_href && !byte_phase) begin
            red_q <= cam_data[3:0];
        end
        if (cam_href && byte_phase) begin
            cap_addr <= pix_cnt;
            cap_data <= {red_q, cam_data};
        end
    end

endmodule

// ==== frame_buffer.sv ====
/* Frame memory of IMG_PIXELS RGB444 words, one write port and one read port
   on the same clock. Read data appears one cycle after the address. */
`timescale 1ns/1ps
`include "cam_consts.svh"

module frame_buffer
    import video_pkg::*;
(
    input  logic      clk_25_vga,
    input  logic      wr_en,
    input  pix_addr_t wr_addr,
    input  rgb444_t   wr_data,
    input  pix_addr_t rd_addr,
    output rgb444_t   rd_data
);

    rgb444_t mem [`IMG_PIXELS];

    always_ff @(posedge clk_25_vga) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

    // Every writer must stay inside the image
    assert property (@(posedge clk_25_vga) wr_en |-> (wr_addr < `IMG_PIXELS))
        else $error("frame buffer write outside the image");

endmodule

// ==== gray_converter.sv ====
/* Gray pass. Walks frame buffer 1, reading each pixel and writing back
   (r + 2g + b) / 4 in all three channels one cycle later. */
`timescale 1ns/1ps
`include "cam_consts.svh"

module gray_converter
    import video_pkg::*;
(
    input  logic      clk_25_vga,
    input  logic      reset_global,
    input  logic      clear,
    input  logic      run,
    output pix_addr_t rd_addr,
    input  rgb444_t   rd_data,
    output logic      wr_en,
    output pix_addr_t wr_addr,
    output rgb444_t   wr_data,
    output logic      done
);

    localparam pix_addr_t LAST_ADDR = pix_addr_t'(`IMG_PIXELS - 1);

    pix_addr_t  addr;
    pix_addr_t  pend_addr;
    logic       pend;
    logic       walk_end;
    logic [5:0] luma_sum;
    nibble_t    luma;

    always_ff @(posedge clk_25_vga or posedge reset_global) begin
        if (reset_global) begin
            addr      <= '0;
            pend_addr <= '0;
            pend      <= 1'b0;
            walk_end  <= 1'b0;
            done      <= 1'b0;
        end else if (clear) begin
            addr     <= '0;
            pend     <= 1'b0;
            walk_end <= 1'b0;
            done     <= 1'b0;
        end else begin
            // A read issued now is written back next cycle, even if run drops
            pend <= run & ~walk_end;
            done <= pend & (pend_addr == LAST_ADDR);
            if (run && !walk_end) begin
                pend_addr <= addr;
                if (addr == LAST_ADDR) begin
                    walk_end <= 1'b1;
                end else begin
                    addr <= addr + 1'b1;
                end
            end
        end
    end

    assign luma_sum = {2'b00, rd_data[11:8]} + {1'b0, rd_data[7:4], 1'b0}
                    + {2'b00, rd_data[3:0]};
    assign luma     = luma_sum[5:2];

    assign rd_addr = addr;
    assign wr_en   = pend;
    assign wr_addr = pend_addr;
    assign wr_data = {luma, luma, luma};

endmodule

// ==== edge_filter.sv ====
/* Edge pass. Reads the gray image in frame buffer 1 and writes
   |left - right| + |up - down|, saturated at 15, into frame buffer 2.
   Border pixels are written as 0. */
`timescale 1ns/1ps
`include "cam_consts.svh"

module edge_filter
    import video_pkg::*;
(
    input  logic      clk_25_vga,
    input  logic      reset_global,
    input  logic      clear,
    input  logic      run,
    output pix_addr_t rd_addr,
    input  rgb444_t   rd_data,
    output logic      wr_en,
    output pix_addr_t wr_addr,
    output rgb444_t   wr_data,
    output logic      done
);

    localparam int X_W = $clog2(`IMG_W);
    localparam int Y_W = $clog2(`IMG_H);
    localparam pix_addr_t LAST_ADDR = pix_addr_t'(`IMG_PIXELS - 1);

    typedef enum logic [2:0] {
        ef_pixel,
        ef_read,
        ef_capture,
        ef_write,
        ef_end
    } ef_state_t;

    ef_state_t      state;
    logic [X_W-1:0] x;
    logic [Y_W-1:0] y;
    pix_addr_t      cur;
    logic [1:0]     nb_sel;
    nibble_t        nb [4];
    logic           border;
    nibble_t        diff_h;
    nibble_t        diff_v;
    logic [4:0]     grad_sum;
    nibble_t        edge_val;

    assign border = (x == '0) || (x == X_W'(`IMG_W - 1))
                 || (y == '0) || (y == Y_W'(`IMG_H - 1));

    // Neighbour order is left, right, up, down
    always_comb begin
        case (nb_sel)
            2'd0:    rd_addr = cur - 1'b1;
            2'd1:    rd_addr = cur + 1'b1;
            2'd2:    rd_addr = cur - pix_addr_t'(`IMG_W);
            default: rd_addr = cur + pix_addr_t'(`IMG_W);
        endcase
    end

    assign diff_h   = (nb[0] > nb[1]) ? nb[0] - nb[1] : nb[1] - nb[0];
    assign diff_v   = (nb[2] > nb[3]) ? nb[2] - nb[3] : nb[3] - nb[2];
    assign grad_sum = {1'b0, diff_h} + {1'b0, diff_v};
    assign edge_val = grad_sum[4] ? 4'hf : grad_sum[3:0];

    assign wr_en   = run && ((state == ef_pixel && border) || state == ef_write);
    assign wr_addr = cur;
    assign wr_data = (state == ef_write) ? {edge_val, edge_val, edge_val} : '0;

    always_ff @(posedge clk_25_vga or posedge reset_global) begin
        if (reset_global) begin
            state  <= ef_pixel;
            x      <= '0;
            y      <= '0;
            cur    <= '0;
            nb_sel <= '0;
            done   <= 1'b0;
        end else if (clear) begin
            state  <= ef_pixel;
            x      <= '0;
            y      <= '0;
            cur    <= '0;
            nb_sel <= '0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (wr_en) begin
                // Pixel finished, step to the next one
                if (cur == LAST_ADDR) begin
                    state <= ef_end;
                    done  <= 1'b1;
                end else begin
                    state <= ef_pixel;
                    cur   <= cur + 1'b1;
                    if (x == X_W'(`IMG_W - 1)) begin
                        x <= '0;
                        y <= y + 1'b1;
                    end else begin
                        x <= x + 1'b1;
                    end
                end
            end else if (run) begin
                case (state)
                    ef_pixel: begin
                        nb_sel <= '0;
                        state  <= ef_read;
                    end
                    ef_read:    state <= ef_capture;
                    ef_capture: begin
                        nb_sel <= nb_sel + 1'b1;
                        state  <= (nb_sel == 2'd3) ? ef_write : ef_read;
                    end
                    default: ;
                endcase
            end
        end
    end

    // Gray image, so the red nibble stands for the pixel
    always_ff @(posedge clk_25_vga) begin
        if (run && state == ef_capture) begin
            nb[nb_sel] <= rd_data[11:8];
        end
    end

endmodule

// ==== mode_sequencer.sv ====
/* Mode sequencer. In edge mode, each finished capture starts a gray pass
   over buffer 1 and then an edge pass into buffer 2. Routes the buffer
   ports to capture, the passes or the display according to state. */
`timescale 1ns/1ps

module mode_sequencer
    import video_pkg::*;
    import ctrl_pkg::*;
(
    input  logic      clk_25_vga,
    input  logic      reset_global,
    input  logic      edge_mode,
    input  logic      frame_done,
    input  logic      scan_vsync,
    input  logic      cap_we,
    input  pix_addr_t cap_addr,
    input  rgb444_t   cap_data,
    input  pix_addr_t gray_rd_addr,
    input  logic      gray_wr_en,
    input  pix_addr_t gray_wr_addr,
    input  rgb444_t   gray_wr_data,
    input  logic      gray_done,
    input  pix_addr_t edge_rd_addr,
    input  logic      edge_wr_en,
    input  pix_addr_t edge_wr_addr,
    input  rgb444_t   edge_wr_data,
    input  logic      edge_done,
    output logic      gray_clear,
    output logic      edge_clear,
    output logic      gray_run,
    output logic      edge_run,
    output logic      buf1_we,
    output pix_addr_t buf1_wr_addr,
    output rgb444_t   buf1_wr_data,
    output pix_addr_t buf1_rd_addr,
    input  pix_addr_t scan_addr,
    output logic      buf2_we,
    output pix_addr_t buf2_wr_addr,
    output rgb444_t   buf2_wr_data,
    output logic      disp_sel,
    output logic      busy
);

    seq_state_t state;

    always_ff @(posedge clk_25_vga or posedge reset_global) begin
        if (reset_global) begin
            state <= seq_idle;
        end else begin
            case (state)
                seq_idle:      if (edge_mode && frame_done) state <= seq_gray;
                seq_gray:      if (gray_done) state <= seq_gray_done;
                seq_gray_done: state <= seq_edge;
                seq_edge:      if (edge_done) state <= seq_edge_done;
                default:       state <= seq_idle;
            endcase
        end
    end

    // Gray pass only advances outside the vertical sync pulse
    assign gray_run   = (state == seq_gray) && scan_vsync;
    assign edge_run   = (state == seq_edge);
    assign gray_clear = (state != seq_gray);
    assign edge_clear = (state != seq_edge);
    assign busy       = (state != seq_idle);
    assign disp_sel   = edge_mode;

    always_comb begin
        buf1_we      = 1'b0;
        buf1_wr_addr = cap_addr;
        buf1_wr_data = cap_data;
        buf1_rd_addr = scan_addr;
        case (state)
            seq_idle: buf1_we = cap_we;
            seq_gray, seq_gray_done: begin
                buf1_we      = gray_wr_en;
                buf1_wr_addr = gray_wr_addr;
                buf1_wr_data = gray_wr_data;
                buf1_rd_addr = gray_rd_addr;
            end
            default: buf1_rd_addr = edge_rd_addr;
        endcase
    end

    // Buffer 2 only ever takes edge results
    assign buf2_we      = (state == seq_edge) && edge_wr_en;
    assign buf2_wr_addr = edge_wr_addr;
    assign buf2_wr_data = edge_wr_data;

    // An edge write outside seq_edge would never reach buffer 2
    assert property (@(posedge clk_25_vga) disable iff (reset_global)
        edge_wr_en |-> (state == seq_edge))
        else $error("edge pass wrote outside seq_edge");

endmodule

// ==== vga_scan.sv ====
/* VGA output side. Counts the raster, decodes sync and blank, issues the
   frame buffer read one cycle ahead and expands the nibbles to 8 bits. */
`timescale 1ns/1ps
`include "cam_consts.svh"

module vga_scan
    import video_pkg::*;
(
    input  logic       clk_25_vga,
    input  logic       reset_global,
    input  logic       disp_sel,
    input  rgb444_t    buf1_data,
    input  rgb444_t    buf2_data,
    output pix_addr_t  scan_addr,
    output logic       hsync,
    output logic       vsync,
    output logic       blank_n,
    output logic [7:0] vga_r,
    output logic [7:0] vga_g,
    output logic [7:0] vga_b
);

    localparam int H_W = $clog2(`H_TOTAL);
    localparam int V_W = $clog2(`V_TOTAL);

    logic [H_W-1:0] h;
    logic [H_W-1:0] h_next;
    logic [V_W-1:0] v;
    logic [V_W-1:0] v_next;
    logic           active;
    logic           next_active;
    logic           hs_pulse;
    logic           vs_pulse;
    rgb444_t        pix;

    always_comb begin
        h_next = h + 1'b1;
        v_next = v;
        if (h == H_W'(`H_TOTAL - 1)) begin
            h_next = '0;
            v_next = (v == V_W'(`V_TOTAL - 1)) ? '0 : v + 1'b1;
        end
    end

    assign active      = (h < `IMG_W) && (v < `IMG_H);
    assign next_active = (h_next < `IMG_W) && (v_next < `IMG_H);
    assign hs_pulse    = (h >= `H_SYNC_START) && (h < `H_SYNC_START + `H_SYNC_LEN);
    assign vs_pulse    = (v >= `V_SYNC_START) && (v < `V_SYNC_START + `V_SYNC_LEN);

    // Address for the next position, so its data lines up with h and v
    assign scan_addr = next_active ? pix_addr_t'(v_next * `IMG_W + h_next) : '0;
    assign pix       = disp_sel ? buf2_data : buf1_data;

    always_ff @(posedge clk_25_vga or posedge reset_global) begin
        if (reset_global) begin
            h       <= '0;
            v       <= '0;
            hsync   <= 1'b1;
            vsync   <= 1'b1;
            blank_n <= 1'b0;
            vga_r   <= '0;
            vga_g   <= '0;
            vga_b   <= '0;
        end else begin
            h       <= h_next;
            v       <= v_next;
            hsync   <= ~hs_pulse;
            vsync   <= ~vs_pulse;
            blank_n <= active;
            vga_r   <= active ? {pix[11:8], pix[11:8]} : 8'h00;
            vga_g   <= active ? {pix[7:4], pix[7:4]} : 8'h00;
            vga_b   <= active ? {pix[3:0], pix[3:0]} : 8'h00;
        end
    end

    assert property (@(posedge clk_25_vga) disable iff (reset_global)
        $rose(blank_n) |-> (hsync && vsync))
        else $error("blank_n rose inside a sync pulse");

endmodule

// ==== cam_vga_top.sv ====
/* Camera to VGA top level. Capture feeds frame buffer 1, the sequencer runs
   the gray and edge passes in edge mode, and the scanner shows buffer 1 or 2. */
`timescale 1ns/1ps

module cam_vga_top
    import video_pkg::*;
(
    input  logic       clk_25_vga,
    input  logic       reset_global,
    input  logic       edge_mode,
    input  logic       cam_vsync,
    input  logic       cam_href,
    input  logic [7:0] cam_data,
    output logic       vga_hsync,
    output logic       vga_vsync,
    output logic       vga_blank_n,
    output logic [7:0] vga_r,
    output logic [7:0] vga_g,
    output logic [7:0] vga_b,
    output logic       done_led
);

    logic      cap_we, frame_done;
    pix_addr_t cap_addr;
    rgb444_t   cap_data;

    logic      buf1_we, buf2_we;
    pix_addr_t buf1_wr_addr, buf1_rd_addr, buf2_wr_addr, scan_addr;
    rgb444_t   buf1_wr_data, buf1_rd_data, buf2_wr_data, buf2_rd_data;

    logic      gray_clear, gray_run, gray_wr_en, gray_done;
    pix_addr_t gray_rd_addr, gray_wr_addr;
    rgb444_t   gray_wr_data;

    logic      edge_clear, edge_run, edge_wr_en, edge_done;
    pix_addr_t edge_rd_addr, edge_wr_addr;
    rgb444_t   edge_wr_data;

    logic      disp_sel;

    pixel_capture u_capture (
        .clk_25_vga, .reset_global, .cam_vsync, .cam_href, .cam_data,
        .cap_we, .cap_addr, .cap_data, .frame_done
    );

    frame_buffer u_buf1 (
        .clk_25_vga, .wr_en(buf1_we), .wr_addr(buf1_wr_addr), .wr_data(buf1_wr_data),
        .rd_addr(buf1_rd_addr), .rd_data(buf1_rd_data)
    );

    // Display reads buffer 2 directly, only the edge pass writes it
    frame_buffer u_buf2 (
        .clk_25_vga, .wr_en(buf2_we), .wr_addr(buf2_wr_addr), .wr_data(buf2_wr_data),
        .rd_addr(scan_addr), .rd_data(buf2_rd_data)
    );

    gray_converter u_gray (
        .clk_25_vga, .reset_global, .clear(gray_clear), .run(gray_run),
        .rd_addr(gray_rd_addr), .rd_data(buf1_rd_data), .wr_en(gray_wr_en),
        .wr_addr(gray_wr_addr), .wr_data(gray_wr_data), .done(gray_done)
    );

    edge_filter u_edge (
        .clk_25_vga, .reset_global, .clear(edge_clear), .run(edge_run),
        .rd_addr(edge_rd_addr), .rd_data(buf1_rd_data), .wr_en(edge_wr_en),
        .wr_addr(edge_wr_addr), .wr_data(edge_wr_data), .done(edge_done)
    );

    mode_sequencer u_seq (
        .clk_25_vga, .reset_global, .edge_mode, .frame_done, .scan_vsync(vga_vsync),
        .cap_we, .cap_addr, .cap_data,
        .gray_rd_addr, .gray_wr_en, .gray_wr_addr, .gray_wr_data, .gray_done,
        .edge_rd_addr, .edge_wr_en, .edge_wr_addr, .edge_wr_data, .edge_done,
        .gray_clear, .edge_clear, .gray_run, .edge_run,
        .buf1_we, .buf1_wr_addr, .buf1_wr_data, .buf1_rd_addr, .scan_addr,
        .buf2_we, .buf2_wr_addr, .buf2_wr_data, .disp_sel, .busy(done_led)
    );

    vga_scan u_scan (
        .clk_25_vga, .reset_global, .disp_sel,
        .buf1_data(buf1_rd_data), .buf2_data(buf2_rd_data), .scan_addr,
        .hsync(vga_hsync), .vsync(vga_vsync), .blank_n(vga_blank_n),
        .vga_r, .vga_g, .vga_b
    );

endmodule

// ==== tb_cam_vga.sv ====
/* Directed testbench for the camera to VGA top level. Drives camera frames,
   grabs the VGA output frame by frame and compares it with a model of the
   gray and edge passes. Run through tb.f with the Makefile. */
`timescale 1ns/1ps
`include "cam_consts.svh"

module tb_cam_vga;

    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    localparam int WAIT_LIMIT   = 3 * FRAME_CYCLES;
    localparam int PASS_LIMIT   = 40000;

    logic       clk_25_vga;
    logic       reset_global;
    logic       edge_mode;
    logic       cam_vsync;
    logic       cam_href;
    logic [7:0] cam_data;
    logic       vga_hsync;
    logic       vga_vsync;
    logic       vga_blank_n;
    logic [7:0] vga_r;
    logic [7:0] vga_g;
    logic [7:0] vga_b;
    logic       done_led;

    logic [11:0] sent_pix [`IMG_PIXELS];
    logic [23:0] exp_pix [`IMG_PIXELS];
    logic [23:0] grab_pix [`IMG_PIXELS];
    int          errors;
    int          checks;
    int          seed;

    cam_vga_top dut (
        .clk_25_vga, .reset_global, .edge_mode, .cam_vsync, .cam_href, .cam_data,
        .vga_hsync, .vga_vsync, .vga_blank_n, .vga_r, .vga_g, .vga_b, .done_led
    );

    initial begin
        clk_25_vga = 1'b0;
        forever #5 clk_25_vga = ~clk_25_vga;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[FAIL] %0t: %s got %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    // Sends one random frame as byte pairs with short gaps between lines
    task automatic send_frame();
        logic [15:0] rnd;
        int          x;
        int          y;
        @(posedge clk_25_vga);
        cam_vsync <= 1'b1;
        cam_href  <= 1'b0;
        repeat (4) @(posedge clk_25_vga);
        cam_vsync <= 1'b0;
        repeat (4) @(posedge clk_25_vga);
        for (y = 0; y < `IMG_H; y++) begin
            for (x = 0; x < `IMG_W; x++) begin
                rnd = 16'($random(seed));
                sent_pix[y * `IMG_W + x] = rnd[11:0];
                // High nibble of the first byte is junk the capture must ignore
                cam_href <= 1'b1;
                cam_data <= {rnd[15:12], rnd[11:8]};
                @(posedge clk_25_vga);
                cam_data <= rnd[7:0];
                @(posedge clk_25_vga);
            end
            cam_href <= 1'b0;
            cam_data <= 8'h00;
            repeat (4) @(posedge clk_25_vga);
        end
        cam_vsync <= 1'b1;
        repeat (4) @(posedge clk_25_vga);
    endtask

    function automatic void direct_reference();
        int i;
        for (i = 0; i < `IMG_PIXELS; i++) begin
            exp_pix[i] = {sent_pix[i][11:8], sent_pix[i][11:8], sent_pix[i][7:4],
                          sent_pix[i][7:4], sent_pix[i][3:0], sent_pix[i][3:0]};
        end
    endfunction

    // Gray is (r + 2g + b) / 4 and edge is |l - r| + |u - d| capped at 15
    function automatic void edge_reference();
        int gray [`IMG_PIXELS];
        int i;
        int x;
        int y;
        int dh;
        int dv;
        int mag;
        for (i = 0; i < `IMG_PIXELS; i++) begin
            gray[i] = (int'(sent_pix[i][11:8]) + 2 * int'(sent_pix[i][7:4])
                      + int'(sent_pix[i][3:0])) / 4;
        end
        for (y = 0; y < `IMG_H; y++) begin
            for (x = 0; x < `IMG_W; x++) begin
                i = y * `IMG_W + x;
                if (x == 0 || x == `IMG_W - 1 || y == 0 || y == `IMG_H - 1) begin
                    mag = 0;
                end else begin
                    dh = gray[i - 1] - gray[i + 1];
                    dv = gray[i - `IMG_W] - gray[i + `IMG_W];
                    dh = (dh < 0) ? -dh : dh;
                    dv = (dv < 0) ? -dv : dv;
                    mag = (dh + dv > 15) ? 15 : dh + dv;
                end
                exp_pix[i] = {6{mag[3:0]}};
            end
        end
    endfunction

    task automatic wait_done_led(input logic level, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk_25_vga);
        while (done_led !== level && cycles < PASS_LIMIT) begin
            @(negedge clk_25_vga);
            cycles++;
        end
        if (done_led !== level) begin
            errors++;
            $display("Timeout: done_led never went to %0d %s", level, what);
        end
    endtask

    // Grabs from one falling vsync to the next and checks raster and pixels
    task automatic grab_and_check(input string what);
        int   n;
        int   hpulses;
        int   cycles;
        int   i;
        logic prev_vs;
        logic prev_hs;
        logic found;
        cycles = 0;
        found  = 1'b0;
        @(negedge clk_25_vga);
        prev_vs = vga_vsync;
        while (!found && cycles < WAIT_LIMIT) begin
            @(negedge clk_25_vga);
            found   = prev_vs && !vga_vsync;
            prev_vs = vga_vsync;
            cycles++;
        end
        if (!found) begin
            errors++;
            $display("Timeout: no falling vsync before the %s frame", what);
        end
        n       = 0;
        hpulses = 0;
        cycles  = 0;
        found   = 1'b0;
        prev_hs = vga_hsync;
        while (!found && cycles < WAIT_LIMIT) begin
            @(negedge clk_25_vga);
            cycles++;
            found = prev_vs && !vga_vsync;
            if (!found) begin
                if (vga_blank_n) begin
                    if (n < `IMG_PIXELS) begin
                        grab_pix[n] = {vga_r, vga_g, vga_b};
                    end
                    n++;
                end
                if (prev_hs && !vga_hsync) begin
                    hpulses++;
                end
            end
            prev_vs = vga_vsync;
            prev_hs = vga_hsync;
        end
        if (!found) begin
            errors++;
            $display("Timeout: the %s frame never ended with a falling vsync", what);
        end
        check_value({what, " blank_n high cycles"}, n, `IMG_PIXELS);
        check_value({what, " hsync pulses"}, hpulses, `V_TOTAL);
        for (i = 0; i < `IMG_PIXELS; i++) begin
            check_value($sformatf("%s pixel %0d", what, i), grab_pix[i], exp_pix[i]);
        end
    endtask

    task automatic reset_state_test();
        repeat (4) @(posedge clk_25_vga);
        @(negedge clk_25_vga);
        check_value("vga_r in reset", vga_r, 0);
        check_value("vga_g in reset", vga_g, 0);
        check_value("vga_b in reset", vga_b, 0);
        check_value("blank_n in reset", vga_blank_n, 0);
        check_value("done_led in reset", done_led, 0);
        check_value("hsync in reset", vga_hsync, 1);
        check_value("vsync in reset", vga_vsync, 1);
        @(posedge clk_25_vga);
        reset_global <= 1'b0;
    endtask

    task automatic normal_mode_test();
        send_frame();
        direct_reference();
        grab_and_check("normal");
    endtask

    task automatic edge_mode_test();
        @(posedge clk_25_vga);
        edge_mode <= 1'b1;
        send_frame();
        wait_done_led(1'b1, "after the edge frame");
        wait_done_led(1'b0, "at the end of the passes");
        edge_reference();
        grab_and_check("edge");
    endtask

    task automatic back_to_normal_test();
        @(posedge clk_25_vga);
        edge_mode <= 1'b0;
        send_frame();
        direct_reference();
        grab_and_check("back to normal");
    endtask

    initial begin
        seed         = 32'h29cb8852;
        errors       = 0;
        checks       = 0;
        reset_global = 1'b1;
        edge_mode    = 1'b0;
        cam_vsync    = 1'b1;
        cam_href     = 1'b0;
        cam_data     = 8'h00;
        reset_state_test();
        normal_mode_test();
        edge_mode_test();
        back_to_normal_test();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+.
video_pkg.sv
ctrl_pkg.sv
pixel_capture.sv
frame_buffer.sv
gray_converter.sv
edge_filter.sv
mode_sequencer.sv
vga_scan.sv
cam_vga_top.sv
tb_cam_vga.sv

// ==== Makefile ====
# Verilator build and run of the camera to VGA testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cam_vga -f tb.f
	@out="$$(./obj_dir/Vtb_cam_vga)"; echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir
